/* tl_pkg.sv */
// TileLink-UL bus types, opcodes and address map for the main crossbar
package tl_pkg;

  // Topology defaults
  parameter int NUM_HOSTS = 2;
  parameter int NUM_DEVS  = 3;

  // Device indices on the host side of the crossbar
  parameter int DEV_ICCM = 0;
  parameter int DEV_DCCM = 1;
  parameter int DEV_PERI = 2;

  // Window base addresses and don't-care masks
  parameter logic [31:0] ADDR_SPACE_ICCM = 32'h0000_0000;
  parameter logic [31:0] ADDR_MASK_ICCM  = 32'h0000_ffff;
  parameter logic [31:0] ADDR_SPACE_DCCM = 32'h1000_0000;
  parameter logic [31:0] ADDR_MASK_DCCM  = 32'h0000_ffff;
  parameter logic [31:0] ADDR_SPACE_PERI = 32'h4000_0000;
  parameter logic [31:0] ADDR_MASK_PERI  = 32'h0000_0fff;

  // Map indexed by device number in DEV_* order
  parameter logic [31:0] DEV_ADDR_SPACE [NUM_DEVS] = '{
    ADDR_SPACE_ICCM,
    ADDR_SPACE_DCCM,
    ADDR_SPACE_PERI
  };

  parameter logic [31:0] DEV_ADDR_MASK [NUM_DEVS] = '{
    ADDR_MASK_ICCM,
    ADDR_MASK_DCCM,
    ADDR_MASK_PERI
  };

  // Channel A opcodes in TileLink encoding
  typedef enum logic [2:0] {
    put_full_data = 3'h0,
    get           = 3'h4
  } tl_a_op_e;

  // Channel D opcodes
  typedef enum logic [2:0] {
    access_ack      = 3'h0,
    access_ack_data = 3'h1
  } tl_d_op_e;

  // Channel A request plus D ready from host to device
  typedef struct packed {
    logic        a_valid;
    tl_a_op_e    a_opcode;
    logic [31:0] a_address;
    logic [31:0] a_data;
    logic [1:0]  a_source;
    logic        d_ready;
  } tl_h2d_t;

  // Channel D response plus A ready from device to host
  typedef struct packed {
    logic        d_valid;
    tl_d_op_e    d_opcode;
    logic [31:0] d_data;
    logic [1:0]  d_source;
    logic        d_error;
    logic        a_ready;
  } tl_d2h_t;

endpackage

/* tl_socket_1n.sv */
// Host-side socket that decodes addresses, routes to one device and answers errors
module tl_socket_1n import tl_pkg::*; #(
  parameter int           N         = NUM_DEVS,
  parameter logic [N-1:0] DEV_REACH = {N{1'b1}}
) (
  input  logic    clk_i,
  input  logic    rst_i,
  input  tl_h2d_t tl_h_i,
  output tl_d2h_t tl_h_o,
  output tl_h2d_t tl_d_o [N],
  input  tl_d2h_t tl_d_i [N]
);

  localparam int IdxW = (N > 1) ? $clog2(N) : 1;

  typedef enum logic [1:0] {
    idle,
    wait_dev,
    err_rsp
  } s1n_state_e;

  s1n_state_e     state_q;
  logic [N-1:0]   hit;
  logic           any_hit;
  logic [IdxW-1:0] dev_sel;
  logic [IdxW-1:0] dev_q;
  tl_d_op_e       err_op_q;
  logic [1:0]     err_source_q;
  logic           a_fire;
  logic           d_fire;

  // Window match limited to the devices this host may reach
  always_comb begin
    hit = '0;
    dev_sel = '0;
    for (int j = 0; j < N; j++) begin
      hit[j] = DEV_REACH[j] &&
               ((tl_h_i.a_address & ~DEV_ADDR_MASK[j]) == DEV_ADDR_SPACE[j]);
    end
    // Lowest index wins if windows ever overlap
    for (int j = N - 1; j >= 0; j--) begin
      if (hit[j]) begin
        dev_sel = IdxW'(j);
      end
    end
  end

  assign any_hit = |hit;

  // Request goes out only when idle and D ready only to the outstanding device
  always_comb begin
    for (int j = 0; j < N; j++) begin
      tl_d_o[j] = tl_h_i;
      tl_d_o[j].a_valid = tl_h_i.a_valid && (state_q == idle) && any_hit &&
                          (dev_sel == IdxW'(j));
      tl_d_o[j].d_ready = tl_h_i.d_ready && (state_q == wait_dev) &&
                          (dev_q == IdxW'(j));
    end
  end

  always_comb begin
    tl_h_o = '0;
    case (state_q)
      idle: begin
        // Unmapped requests are taken at once by the error responder
        tl_h_o.a_ready = any_hit ? tl_d_i[dev_sel].a_ready : 1'b1;
      end
      wait_dev: begin
        tl_h_o = tl_d_i[dev_q];
        tl_h_o.a_ready = 1'b0;
      end
      err_rsp: begin
        tl_h_o.d_valid  = 1'b1;
        tl_h_o.d_opcode = err_op_q;
        tl_h_o.d_source = err_source_q;
        tl_h_o.d_error  = 1'b1;
      end
      default: begin
        tl_h_o = '0;
      end
    endcase
  end

  assign a_fire = tl_h_i.a_valid && tl_h_o.a_ready;
  assign d_fire = tl_h_o.d_valid && tl_h_i.d_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= idle;
    end else begin
      case (state_q)
        idle: begin
          if (a_fire) begin
            state_q <= any_hit ? wait_dev : err_rsp;
          end
        end
        wait_dev, err_rsp: begin
          if (d_fire) begin
            state_q <= idle;
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

  // Target and error reply fields captured on acceptance
  always_ff @(posedge clk_i) begin
    if ((state_q == idle) && a_fire) begin
      dev_q        <= dev_sel;
      err_op_q     <= (tl_h_i.a_opcode == get) ? access_ack_data : access_ack;
      err_source_q <= tl_h_i.a_source;
    end
  end

endmodule

/* tl_socket_m1.sv */
// Device-side socket with round-robin arbitration and response return to the owner
module tl_socket_m1 import tl_pkg::*; #(
  parameter int M = NUM_HOSTS
) (
  input  logic    clk_i,
  input  logic    rst_i,
  input  tl_h2d_t tl_h_i [M],
  output tl_d2h_t tl_h_o [M],
  output tl_h2d_t tl_d_o,
  input  tl_d2h_t tl_d_i
);

  localparam int IdxW = (M > 1) ? $clog2(M) : 1;

  typedef enum logic {
    idle,
    busy
  } sm1_state_e;

  sm1_state_e      state_q;
  logic [IdxW-1:0] owner_q;
  logic [IdxW-1:0] ptr_q;
  logic [M-1:0]    req;
  logic            gnt_valid;
  logic [IdxW-1:0] gnt_idx;
  logic [IdxW-1:0] sel;
  logic            a_fire;
  logic            d_fire;

  always_comb begin
    for (int i = 0; i < M; i++) begin
      req[i] = tl_h_i[i].a_valid;
    end
  end

  // Search starts at the pointer and wraps around
  always_comb begin
    int idx;
    gnt_valid = 1'b0;
    gnt_idx = '0;
    for (int k = 0; k < M; k++) begin
      idx = (int'(ptr_q) + k) % M;
      if (!gnt_valid && req[idx]) begin
        gnt_valid = 1'b1;
        gnt_idx = IdxW'(idx);
      end
    end
  end

  // Owner while the transaction is open and winner otherwise
  assign sel = (state_q == busy) ? owner_q : gnt_idx;

  always_comb begin
    tl_d_o = tl_h_i[sel];
    tl_d_o.a_valid = (state_q == idle) && gnt_valid;
    tl_d_o.d_ready = (state_q == busy) && tl_h_i[owner_q].d_ready;
  end

  always_comb begin
    for (int i = 0; i < M; i++) begin
      tl_h_o[i] = tl_d_i;
      tl_h_o[i].d_valid = tl_d_i.d_valid && (state_q == busy) &&
                          (owner_q == IdxW'(i));
      tl_h_o[i].a_ready = tl_d_i.a_ready && (state_q == idle) && gnt_valid &&
                          (gnt_idx == IdxW'(i));
    end
  end

  assign a_fire = tl_d_o.a_valid && tl_d_i.a_ready;
  assign d_fire = tl_d_i.d_valid && tl_d_o.d_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= idle;
      owner_q <= '0;
      ptr_q   <= '0;
    end else begin
      case (state_q)
        idle: begin
          if (a_fire) begin
            state_q <= busy;
            owner_q <= gnt_idx;
            // Next search begins just past the winner
            ptr_q   <= (int'(gnt_idx) == M - 1) ? '0 : gnt_idx + 1'b1;
          end
        end
        busy: begin
          if (d_fire) begin
            state_q <= idle;
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

endmodule

/* tl_xbar_main.sv */
// Main crossbar joining the ifu and lsu hosts to the iccm, dccm and peri devices
module tl_xbar_main import tl_pkg::*; #(
  parameter int NUM_HOSTS = tl_pkg::NUM_HOSTS,
  parameter int NUM_DEVS  = tl_pkg::NUM_DEVS
) (
  input  logic    clk_i,
  input  logic    rst_i,

  // Hosts
  input  tl_h2d_t tl_ifu_i,
  output tl_d2h_t tl_ifu_o,
  input  tl_h2d_t tl_lsu_i,
  output tl_d2h_t tl_lsu_o,

  // Devices
  output tl_h2d_t tl_iccm_o,
  input  tl_d2h_t tl_iccm_i,
  output tl_h2d_t tl_dccm_o,
  input  tl_d2h_t tl_dccm_i,
  output tl_h2d_t tl_peri_o,
  input  tl_d2h_t tl_peri_i
);

  localparam int HOST_IFU = 0;
  localparam int HOST_LSU = 1;

  // Instruction fetch never reaches dccm
  localparam logic [NUM_DEVS-1:0] IFU_REACH =
    NUM_DEVS'((1 << DEV_ICCM) | (1 << DEV_PERI));
  localparam logic [NUM_DEVS-1:0] LSU_REACH = {NUM_DEVS{1'b1}};

  // Host socket side indexed by device
  tl_h2d_t ifu_to_dev [NUM_DEVS];
  tl_d2h_t dev_to_ifu [NUM_DEVS];
  tl_h2d_t lsu_to_dev [NUM_DEVS];
  tl_d2h_t dev_to_lsu [NUM_DEVS];

  // Device socket side indexed by host
  tl_h2d_t iccm_req [NUM_HOSTS];
  tl_d2h_t iccm_rsp [NUM_HOSTS];
  tl_h2d_t dccm_req [NUM_HOSTS];
  tl_d2h_t dccm_rsp [NUM_HOSTS];
  tl_h2d_t peri_req [NUM_HOSTS];
  tl_d2h_t peri_rsp [NUM_HOSTS];

  // iccm
  assign iccm_req[HOST_IFU]   = ifu_to_dev[DEV_ICCM];
  assign iccm_req[HOST_LSU]   = lsu_to_dev[DEV_ICCM];
  assign dev_to_ifu[DEV_ICCM] = iccm_rsp[HOST_IFU];
  assign dev_to_lsu[DEV_ICCM] = iccm_rsp[HOST_LSU];

  // The ifu input of dccm stays idle
  assign dccm_req[HOST_IFU]   = ifu_to_dev[DEV_DCCM];
  assign dccm_req[HOST_LSU]   = lsu_to_dev[DEV_DCCM];
  assign dev_to_ifu[DEV_DCCM] = dccm_rsp[HOST_IFU];
  assign dev_to_lsu[DEV_DCCM] = dccm_rsp[HOST_LSU];

  // peri
  assign peri_req[HOST_IFU]   = ifu_to_dev[DEV_PERI];
  assign peri_req[HOST_LSU]   = lsu_to_dev[DEV_PERI];
  assign dev_to_ifu[DEV_PERI] = peri_rsp[HOST_IFU];
  assign dev_to_lsu[DEV_PERI] = peri_rsp[HOST_LSU];

  tl_socket_1n #(
    .N         (NUM_DEVS),
    .DEV_REACH (IFU_REACH)
  ) host_ifu (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .tl_h_i (tl_ifu_i),
    .tl_h_o (tl_ifu_o),
    .tl_d_o (ifu_to_dev),
    .tl_d_i (dev_to_ifu)
  );

  tl_socket_1n #(
    .N         (NUM_DEVS),
    .DEV_REACH (LSU_REACH)
  ) host_lsu (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .tl_h_i (tl_lsu_i),
    .tl_h_o (tl_lsu_o),
    .tl_d_o (lsu_to_dev),
    .tl_d_i (dev_to_lsu)
  );

  tl_socket_m1 #(
    .M (NUM_HOSTS)
  ) dev_iccm (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .tl_h_i (iccm_req),
    .tl_h_o (iccm_rsp),
    .tl_d_o (tl_iccm_o),
    .tl_d_i (tl_iccm_i)
  );

  tl_socket_m1 #(
    .M (NUM_HOSTS)
  ) dev_dccm (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .tl_h_i (dccm_req),
    .tl_h_o (dccm_rsp),
    .tl_d_o (tl_dccm_o),
    .tl_d_i (tl_dccm_i)
  );

  tl_socket_m1 #(
    .M (NUM_HOSTS)
  ) dev_peri (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .tl_h_i (peri_req),
    .tl_h_o (peri_rsp),
    .tl_d_o (tl_peri_o),
    .tl_d_i (tl_peri_i)
  );

endmodule

/* tb_mem_device.sv */
// Testbench memory device that answers each request after a short random delay
module tb_mem_device import tl_pkg::*; #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  logic    clk_i,
  input  logic    rst_i,
  input  tl_h2d_t tl_i,
  output tl_d2h_t tl_o
);

  logic [31:0] mem [logic [31:0]];
  integer      seed = SEED;
  tl_d2h_t     rsp_q = '0;
  tl_h2d_t     req_q = '0;
  logic        waiting = 1'b0;
  logic [1:0]  wait_cnt = '0;

  assign tl_o = rsp_q;

  always @(posedge clk_i) begin
    if (rst_i) begin
      rsp_q <= '0;
      rsp_q.a_ready <= 1'b1;
      waiting <= 1'b0;
    end else if (rsp_q.a_ready && tl_i.a_valid) begin
      req_q <= tl_i;
      rsp_q.a_ready <= 1'b0;
      waiting <= 1'b1;
      // Extra wait of 0 to 3 cycles
      wait_cnt <= 2'($random(seed));
    end else if (waiting) begin
      if (wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
      end else begin
        waiting <= 1'b0;
        rsp_q.d_valid <= 1'b1;
        rsp_q.d_source <= req_q.a_source;
        rsp_q.d_error <= 1'b0;
        if (req_q.a_opcode == put_full_data) begin
          mem[req_q.a_address] = req_q.a_data;
          rsp_q.d_opcode <= access_ack;
          rsp_q.d_data <= '0;
        end else begin
          rsp_q.d_opcode <= access_ack_data;
          // Never written reads as zero
          rsp_q.d_data <= mem.exists(req_q.a_address) ? mem[req_q.a_address] : '0;
        end
      end
    end else if (rsp_q.d_valid && tl_i.d_ready) begin
      rsp_q.d_valid <= 1'b0;
      rsp_q.a_ready <= 1'b1;
    end
  end

endmodule

/* tb_xbar_main.sv */
// Testbench for the main crossbar with random traffic on both hosts against a reference model
module tb_xbar_main import tl_pkg::*; ();

  localparam int          NUM_TXN = 300;
  localparam int          MAX_GAP = 4;
  localparam int          PERIOD  = 40;
  localparam logic [31:0] SEED    = 32'h9c91_3b2a;
  localparam logic [1:0]  NO_DEV  = 2'd3;
  localparam int          TIMEOUT = 2 * NUM_TXN * 20 * PERIOD;

  // One open host transaction as the model sees it
  typedef struct packed {
    logic        busy;
    logic        routed;
    logic [1:0]  dev;
    tl_a_op_e    op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rdata;
  } txn_t;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        rst_q = 1'b1;
  integer      seed = SEED;
  tl_h2d_t     host_req [2] = '{default: '0};
  tl_d2h_t     host_rsp [2];
  tl_h2d_t     dev_req [3];
  tl_d2h_t     dev_rsp [3];
  txn_t        pend [2] = '{default: '0};
  tl_d2h_t     held [2];
  logic        held_v [2] = '{default: 1'b0};
  logic [1:0]  last_win [3] = '{default: 2'd1};
  int          issued [2] = '{default: 0};
  int          gap [2] = '{default: 0};
  int          rsp_cnt [2] = '{default: 0};
  // Keyed by device index and address
  logic [31:0] model_mem [logic [33:0]];

  tl_xbar_main DUT (
    .clk_i     (clk),
    .rst_i     (rst),
    .tl_ifu_i  (host_req[0]),
    .tl_ifu_o  (host_rsp[0]),
    .tl_lsu_i  (host_req[1]),
    .tl_lsu_o  (host_rsp[1]),
    .tl_iccm_o (dev_req[0]),
    .tl_iccm_i (dev_rsp[0]),
    .tl_dccm_o (dev_req[1]),
    .tl_dccm_i (dev_rsp[1]),
    .tl_peri_o (dev_req[2]),
    .tl_peri_i (dev_rsp[2])
  );

  for (genvar d = 0; d < 3; d++) begin : g_dev
    tb_mem_device #(
      .SEED (SEED ^ 32'(d))
    ) mem_dev (
      .clk_i (clk),
      .rst_i (rst),
      .tl_i  (dev_req[d]),
      .tl_o  (dev_rsp[d])
    );
  end

  always #(PERIOD / 2) clk = ~clk;

  task automatic fail_run(string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(string sig, logic [31:0] expv, logic [31:0] actv);
    fail_run($sformatf("MISMATCH time %0t %s expected %h actual %h",
                       $time, sig, expv, actv));
  endtask

  // Target from the address map and the host's reach where ifu never gets dccm
  function automatic logic [1:0] route_of(int host, logic [31:0] addr);
    if (addr[31:16] == 16'h0000) begin
      return 2'd0;
    end else if (addr[31:16] == 16'h1000) begin
      return (host == 1) ? 2'd1 : NO_DEV;
    end else if (addr[31:12] == 20'h4_0000) begin
      return 2'd2;
    end
    return NO_DEV;
  endfunction

  // Mostly mapped windows with a few holes and eight words per window
  function automatic tl_h2d_t rand_req(int host);
    tl_h2d_t     r;
    logic [3:0]  kind;
    logic [31:0] base;
    kind = 4'($random(seed));
    if (kind < 4'd5) begin
      base = 32'h0000_0000;
    end else if (kind < 4'd10) begin
      base = 32'h1000_0000;
    end else if (kind < 4'd14) begin
      base = 32'h4000_0000;
    end else if (kind == 4'd14) begin
      base = 32'h2000_0000;
    end else begin
      base = 32'h4000_1000;
    end
    r = '0;
    r.a_valid = 1'b1;
    r.a_opcode = (($random(seed) & 1) != 0) ? get : put_full_data;
    r.a_address = base | {27'd0, 3'($random(seed)), 2'b00};
    r.a_data = $random(seed);
    r.a_source = 2'(host);
    return r;
  endfunction

  task automatic check_device_request(int d, logic contend);
    logic [1:0]  s;
    logic [33:0] key;
    s = dev_req[d].a_source;
    assert (s < 2'd2 && pend[s[0]].busy && !pend[s[0]].routed && pend[s[0]].dev == 2'(d))
    else fail_run($sformatf("ERROR time %0t device %0d got a request no host sent to it",
                            $time, d));
    assert (dev_req[d].a_address == pend[s[0]].addr)
    else report_mismatch($sformatf("dev%0d.a_address", d), pend[s[0]].addr,
                         dev_req[d].a_address);
    assert (dev_req[d].a_data == pend[s[0]].data)
    else report_mismatch($sformatf("dev%0d.a_data", d), pend[s[0]].data, dev_req[d].a_data);
    assert (dev_req[d].a_opcode == pend[s[0]].op)
    else report_mismatch($sformatf("dev%0d.a_opcode", d), 32'(pend[s[0]].op),
                         32'(dev_req[d].a_opcode));
    // Both hosts wait on this device so the grant must switch
    if (contend) begin
      assert (s != last_win[d])
      else report_mismatch($sformatf("dev%0d.a_source", d), 32'(last_win[d] ^ 2'd1), 32'(s));
    end
    last_win[d] = s;
    key = {2'(d), dev_req[d].a_address};
    pend[s[0]].routed = 1'b1;
    if (pend[s[0]].op == put_full_data) begin
      model_mem[key] = dev_req[d].a_data;
    end else begin
      pend[s[0]].rdata = model_mem.exists(key) ? model_mem[key] : '0;
    end
  endtask

  task automatic check_response(int h);
    tl_d_op_e exp_op;
    exp_op = (pend[h].op == get) ? access_ack_data : access_ack;
    assert (host_rsp[h].d_source == 2'(h))
    else report_mismatch($sformatf("host%0d.d_source", h), 32'(h), 32'(host_rsp[h].d_source));
    assert (host_rsp[h].d_opcode == exp_op)
    else report_mismatch($sformatf("host%0d.d_opcode", h), 32'(exp_op),
                         32'(host_rsp[h].d_opcode));
    if (pend[h].dev == NO_DEV) begin
      assert (host_rsp[h].d_error)
      else report_mismatch($sformatf("host%0d.d_error", h), 32'd1, 32'd0);
      assert (host_rsp[h].d_data == '0)
      else report_mismatch($sformatf("host%0d.d_data", h), 32'd0, host_rsp[h].d_data);
    end else begin
      assert (pend[h].routed)
      else fail_run($sformatf("ERROR time %0t host %0d answered before its request reached a device",
                              $time, h));
      assert (!host_rsp[h].d_error)
      else report_mismatch($sformatf("host%0d.d_error", h), 32'd0, 32'd1);
      if (pend[h].op == get) begin
        assert (host_rsp[h].d_data == pend[h].rdata)
        else report_mismatch($sformatf("host%0d.d_data", h), pend[h].rdata,
                             host_rsp[h].d_data);
      end
    end
  endtask

  // Host stimulus with random gaps and random d_ready
  always @(posedge clk) begin
    tl_h2d_t nxt;
    for (int h = 0; h < 2; h++) begin
      nxt = host_req[h];
      if (rst) begin
        nxt = '0;
      end else if (nxt.a_valid && host_rsp[h].a_ready) begin
        nxt.a_valid = 1'b0;
        issued[h] <= issued[h] + 1;
        gap[h] <= $unsigned($random(seed)) % MAX_GAP;
      end else if (!nxt.a_valid && gap[h] > 0) begin
        gap[h] <= gap[h] - 1;
      end else if (!nxt.a_valid && issued[h] < NUM_TXN) begin
        nxt = rand_req(h);
      end
      nxt.d_ready = !rst && (2'($random(seed)) != 2'd0);
      host_req[h] <= nxt;
    end
  end

  // Model and checks on values sampled before the edge updates
  always @(posedge clk) begin
    logic [2:0] contend;
    rst_q <= rst;
    if (rst || rst_q) begin
      for (int i = 0; i < 3; i++) begin
        assert (!dev_req[i].a_valid)
        else fail_run($sformatf("ERROR time %0t device %0d a_valid high around reset", $time, i));
      end
      for (int h = 0; h < 2; h++) begin
        assert (!host_rsp[h].d_valid)
        else fail_run($sformatf("ERROR time %0t host %0d d_valid high around reset", $time, h));
      end
    end
    if (!rst) begin
      for (int h = 0; h < 2; h++) begin
        if (held_v[h]) begin
          assert (host_rsp[h].d_valid && host_rsp[h].d_data == held[h].d_data &&
                  host_rsp[h].d_opcode == held[h].d_opcode &&
                  host_rsp[h].d_source == held[h].d_source &&
                  host_rsp[h].d_error == held[h].d_error)
          else fail_run($sformatf("ERROR time %0t host %0d response changed while stalled",
                                  $time, h));
        end
        held_v[h] = host_rsp[h].d_valid && !host_req[h].d_ready;
        held[h] = host_rsp[h];
      end
      for (int d = 0; d < 3; d++) begin
        contend[d] = !pend[0].busy && !pend[1].busy &&
                     host_req[0].a_valid && host_req[1].a_valid &&
                     (route_of(0, host_req[0].a_address) == 2'(d)) &&
                     (route_of(1, host_req[1].a_address) == 2'(d));
      end
      for (int h = 0; h < 2; h++) begin
        if (host_rsp[h].d_valid) begin
          assert (pend[h].busy)
          else fail_run($sformatf("ERROR time %0t host %0d got a response with nothing open",
                                  $time, h));
          if (host_req[h].d_ready) begin
            check_response(h);
            pend[h].busy = 1'b0;
            rsp_cnt[h] = rsp_cnt[h] + 1;
          end
        end
      end
      for (int h = 0; h < 2; h++) begin
        if (host_req[h].a_valid && host_rsp[h].a_ready) begin
          pend[h] = '0;
          pend[h].busy = 1'b1;
          pend[h].dev = route_of(h, host_req[h].a_address);
          pend[h].op = host_req[h].a_opcode;
          pend[h].addr = host_req[h].a_address;
          pend[h].data = host_req[h].a_data;
        end
      end
      for (int d = 0; d < 3; d++) begin
        if (dev_req[d].a_valid && dev_rsp[d].a_ready) begin
          check_device_request(d, contend[d]);
        end
      end
    end
  end

  initial begin
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    wait (rsp_cnt[0] == NUM_TXN && rsp_cnt[1] == NUM_TXN);
    repeat (5) @(posedge clk);
    if (!pend[0].busy && !pend[1].busy && !dev_req[0].a_valid &&
        !dev_req[1].a_valid && !dev_req[2].a_valid) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      fail_run("ERROR traffic still open after the last response");
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    fail_run($sformatf("ERROR timeout after %0d time units with %0d and %0d responses",
                       TIMEOUT, rsp_cnt[0], rsp_cnt[1]));
  end

endmodule

/* project.f */
tl_pkg.sv
tl_socket_1n.sv
tl_socket_m1.sv
tl_xbar_main.sv
tb_mem_device.sv
tb_xbar_main.sv

/* run.sh */
#!/bin/sh
# Build the crossbar testbench with Verilator, run it, and look for the pass line
verilator --binary --timing --assert -f project.f --top-module tb_xbar_main -o tb_sim || exit 1
out="$(./obj_dir/tb_sim 2>&1)"
echo "$out"
echo "$out" | grep -qx "STATUS: PASS" && exit 0 || exit 1
